// File: tb/ramio_cases.txt
# op addr type data   W write (type = write_type)   R read (type = read_type, data = expected)
# I byte shifted onto uart_rx   T byte expected on uart_tx (addr and type unused)
W 00000010 3 12345678
R 00000010 3 12345678
W 00000011 1 000000ab
W 00000012 2 0000cdef
R 00000010 3 cdefab78
W 00000013 2 0000ffff
R 00000410 3 cdefab78
W 00000020 3 80f17f9c
R 00000020 1 0000009c
R 00000021 5 0000007f
R 00000022 5 fffffff1
R 00000023 1 00000080
R 00000020 6 00007f9c
R 00000022 6 ffff80f1
R 00000022 2 000080f1
R 00000021 2 00000000
R fffffff0 3 0000000f
W fffffff0 3 0000005a
R fffffff0 3 0000000a
R fffffff8 3 ffffffff
W fffffff8 3 000001a5
R fffffff8 3 000000a5
T 00000000 0 000000a5
R fffffff8 3 ffffffff
R fffffff4 3 ffffffff
I 00000000 0 0000003c
R fffffff4 3 0000003c
R fffffff4 3 ffffffff

// File: flist.f
rtl/ramio_pkg.sv
rtl/ram_port_if.sv
rtl/lane_align.sv
rtl/word_ram.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/ramio.sv
tb/tb_clock.sv
tb/ramio_checker.sv
tb/ramio_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ramio testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module ramio_tb -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vramio_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

// File: tb/ramio_tb.sv
/*
  ramio testbench top
  reads the cases file, drives client requests on the falling edge
  and shifts bytes onto uart_rx, the checker does the comparing
*/
`timescale 1ns/1ps

module ramio_tb;
  import ramio_pkg::*;

  logic clk;
  logic rst_n;
  logic enable;
  logic [2:0] read_type;
  logic [1:0] write_type;
  logic [ADDR_W-1:0] address;
  logic [DATA_W-1:0] data_in;
  logic [DATA_W-1:0] data_out;
  logic data_out_ready;
  logic busy;
  logic [3:0] led;
  logic uart_tx;
  logic uart_rx;
  // expectations handed to the checker
  logic [DATA_W-1:0] exp_data;
  logic [7:0] exp_tx_byte;
  logic exp_tx_push;
  logic report;
  logic reported;
  int errors;
  int checks;
  int tx_pending;
  // one entry per case line
  byte ops[$];
  logic [31:0] addrs[$];
  logic [31:0] types[$];
  logic [31:0] vals[$];
  int bad_lines = 0;
  int cycles = 0;
  int limit = 0;

  tb_clock u_clock (.clk(clk), .rst_n(rst_n));

  ramio u_dut (
    .clk(clk),
    .rst_n(rst_n),
    .enable(enable),
    .read_type(read_type),
    .write_type(write_type),
    .address(address),
    .data_in(data_in),
    .data_out(data_out),
    .data_out_ready(data_out_ready),
    .busy(busy),
    .led(led),
    .uart_tx(uart_tx),
    .uart_rx(uart_rx)
  );

  ramio_checker u_checker (
    .clk(clk),
    .rst_n(rst_n),
    .enable(enable),
    .read_type(read_type),
    .write_type(write_type),
    .address(address),
    .data_out(data_out),
    .data_out_ready(data_out_ready),
    .busy(busy),
    .led(led),
    .uart_tx(uart_tx),
    .exp_data(exp_data),
    .exp_tx_byte(exp_tx_byte),
    .exp_tx_push(exp_tx_push),
    .report(report),
    .errors(errors),
    .checks(checks),
    .tx_pending(tx_pending),
    .reported(reported)
  );

  // ------------------------------------------------------------
  // cases file
  // ------------------------------------------------------------
  task automatic read_cases();
    int fd;
    int n;
    string line;
    byte op;
    logic [31:0] a;
    logic [31:0] t;
    logic [31:0] d;
    fd = $fopen("tb/ramio_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open tb/ramio_cases.txt");
      bad_lines++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        // skip blank lines and # comments
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%c %h %h %h", op, a, t, d);
          if (n == 4) begin
            ops.push_back(op);
            addrs.push_back(a);
            types.push_back(t);
            vals.push_back(d);
          end else begin
            $display("cases file line not understood: %s", line);
            bad_lines++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ------------------------------------------------------------
  // client operations, all start on a falling edge
  // ------------------------------------------------------------
  task automatic write_op(input logic [31:0] a, input logic [1:0] wt, input logic [31:0] d);
    @(negedge clk);
    enable = 1'b1;
    address = a;
    write_type = wt;
    data_in = d;
    // RAM and I/O writes both complete in one cycle
    @(negedge clk);
    enable = 1'b0;
    write_type = 2'b00;
  endtask

  task automatic read_op(input logic [31:0] a, input logic [2:0] rt, input logic [31:0] d);
    @(negedge clk);
    exp_data = d;
    enable = 1'b1;
    address = a;
    read_type = rt;
    // I/O answers in its first cycle
    @(negedge clk);
    if (!(a inside {ADDR_LED, ADDR_UART_OUT, ADDR_UART_IN})) begin
      // ready seen here is what the checker sees on the next rising edge
      while (!data_out_ready) @(negedge clk);
      @(negedge clk);
    end
    enable = 1'b0;
    read_type = 3'b000;
  endtask

  task automatic inject_op(input logic [7:0] b);
    logic [9:0] frame;
    // stop, data LSB first, start
    frame = {1'b1, b, 1'b0};
    @(negedge clk);
    repeat (10) begin
      uart_rx = frame[0];
      frame = frame >> 1;
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
    // give the receiver a whole frame to hand the byte over
    repeat (10 * CLKS_PER_BIT) @(negedge clk);
  endtask

  task automatic expect_tx_op(input logic [7:0] b);
    @(negedge clk);
    exp_tx_byte = b;
    exp_tx_push = 1'b1;
    @(negedge clk);
    exp_tx_push = 1'b0;
    while (tx_pending != 0) @(negedge clk);
    // rest of the stop bit plus the release of the staging register
    repeat (CLKS_PER_BIT + 2) @(negedge clk);
  endtask

  // ------------------------------------------------------------
  // run limit
  // ------------------------------------------------------------
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout after %0d cycles with the cases still running", cycles);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    enable = 1'b0;
    read_type = 3'b000;
    write_type = 2'b00;
    address = '0;
    data_in = '0;
    uart_rx = 1'b1;
    exp_data = '0;
    exp_tx_byte = '0;
    exp_tx_push = 1'b0;
    report = 1'b0;
    read_cases();
    limit = ops.size() * (20 * CLKS_PER_BIT + 10);
    while (!rst_n) @(negedge clk);
    foreach (ops[i]) begin
      case (ops[i])
        "W": begin
          write_op(addrs[i], types[i][1:0], vals[i]);
          $display("case %0d write 0x%08h to 0x%08h", i, vals[i], addrs[i]);
        end
        "R": read_op(addrs[i], types[i][2:0], vals[i]);
        "I": begin
          inject_op(vals[i][7:0]);
          $display("case %0d injected 0x%02h on uart_rx", i, vals[i][7:0]);
        end
        "T": expect_tx_op(vals[i][7:0]);
        default: begin
          $display("case %0d has an unknown operation %c", i, ops[i]);
          bad_lines++;
        end
      endcase
    end
    @(negedge clk);
    report = 1'b1;
    while (!reported) @(negedge clk);
    if (errors == 0 && bad_lines == 0 && checks > 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: tb/ramio_checker.sv
/*
  ramio checker
  compares read data and handshake timing on the client port,
  decodes uart_tx frames against the expected bytes
*/
`timescale 1ns/1ps

module ramio_checker (
  input logic clk,
  input logic rst_n,
  input logic enable,
  input logic [2:0] read_type,
  input logic [1:0] write_type,
  input logic [ramio_pkg::ADDR_W-1:0] address,
  input logic [ramio_pkg::DATA_W-1:0] data_out,
  input logic data_out_ready,
  input logic busy,
  input logic [3:0] led,
  input logic uart_tx,
  input logic [ramio_pkg::DATA_W-1:0] exp_data,
  input logic [7:0] exp_tx_byte,
  input logic exp_tx_push,
  input logic report,
  output int errors,
  output int checks,
  output int tx_pending,
  output logic reported
);
  import ramio_pkg::*;

  int rd_errors = 0;
  int rd_checks = 0;
  int tx_errors = 0;
  int tx_checks = 0;
  int missing = 0;
  int req_cycles = 0;
  logic is_io;
  // expected transmit bytes, small ring
  logic [7:0] tx_exp [64];
  logic [5:0] wr_ptr = '0;
  logic [5:0] rd_ptr = '0;
  logic [5:0] tx_diff;
  logic [7:0] tx_got;

  assign is_io = address inside {ADDR_LED, ADDR_UART_OUT, ADDR_UART_IN};
  assign tx_diff = wr_ptr - rd_ptr;
  assign tx_pending = int'(tx_diff);
  assign errors = rd_errors + tx_errors + missing;
  assign checks = rd_checks + tx_checks;

  // ------------------------------------------------------------
  // client port, sampled on the rising edge
  // ------------------------------------------------------------
  always @(posedge clk) begin
    if (!rst_n || !enable) begin
      req_cycles = 0;
    end else begin
      req_cycles = req_cycles + 1;
      if (write_type != 2'b00 && busy) begin
        rd_errors++;
        $display("Error: busy 0x1 expected 0x0 on write to 0x%08h", address);
      end
      if (read_type != 3'b000 && !data_out_ready && !busy) begin
        rd_errors++;
        $display("Error: busy 0x0 expected 0x1 on read of 0x%08h", address);
      end
      if (read_type != 3'b000 && data_out_ready) begin
        rd_checks++;
        // I/O answers at once, the RAM one cycle later
        if (req_cycles != (is_io ? 1 : 2)) begin
          rd_errors++;
          $display("read of 0x%08h answered after %0d cycles instead of %0d",
                   address, req_cycles, is_io ? 1 : 2);
        end
        if (data_out !== exp_data) begin
          rd_errors++;
          $display("Error: data_out 0x%08h expected 0x%08h at address 0x%08h",
                   data_out, exp_data, address);
        end else begin
          $display("read 0x%08h type %0d gave 0x%08h ok", address, read_type, data_out);
        end
        // the led pins carry the same nibble the register reads back
        if (address == ADDR_LED && led !== exp_data[3:0]) begin
          rd_errors++;
          $display("Error: led 0x%01h expected 0x%01h", led, exp_data[3:0]);
        end
      end
    end
  end

  always @(posedge clk) begin
    if (exp_tx_push) begin
      tx_exp[wr_ptr] = exp_tx_byte;
      wr_ptr = wr_ptr + 1'b1;
    end
  end

  // ------------------------------------------------------------
  // uart_tx frame decoder, samples near mid bit
  // ------------------------------------------------------------
  initial begin
    forever begin
      @(posedge clk);
      if (rst_n && !uart_tx) begin
        repeat (CLKS_PER_BIT / 2 - 1) @(posedge clk);
        if (uart_tx) begin
          tx_errors++;
          $display("uart_tx start bit went high again before mid bit");
        end else begin
          // LSB first, shifted in from the top
          repeat (8) begin
            repeat (CLKS_PER_BIT) @(posedge clk);
            tx_got = {uart_tx, tx_got[7:1]};
          end
          repeat (CLKS_PER_BIT) @(posedge clk);
          tx_checks++;
          if (!uart_tx) begin
            tx_errors++;
            $display("uart_tx frame 0x%02h ended with a low stop bit", tx_got);
          end else if (tx_diff == 6'd0) begin
            tx_errors++;
            $display("uart_tx sent 0x%02h while no frame was expected", tx_got);
          end else begin
            if (tx_got !== tx_exp[rd_ptr]) begin
              tx_errors++;
              $display("Error: uart_tx 0x%02h expected 0x%02h", tx_got, tx_exp[rd_ptr]);
            end else begin
              $display("uart_tx frame 0x%02h ok", tx_got);
            end
            rd_ptr = rd_ptr + 1'b1;
          end
        end
      end
    end
  end

  // closing counts
  initial begin
    reported = 1'b0;
    while (!report) @(posedge clk);
    missing = int'(tx_diff);
    if (missing != 0) begin
      $display("%0d expected uart_tx frames never arrived", missing);
    end
    $display("checks %0d, errors %0d", rd_checks + tx_checks, rd_errors + tx_errors + missing);
    reported = 1'b1;
  end

endmodule

// File: tb/tb_clock.sv
/*
  testbench clock and reset
  100 ns clk, rst_n held low for the first two cycles
*/
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // release on a falling edge like every other input
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: rtl/ramio.sv
/*
  ramio bus front end
  decodes client accesses to the local RAM or the LED and UART registers,
  holds the I/O registers and muxes the response back to the client
*/
`timescale 1ns/1ps

module ramio (
  input logic clk,
  input logic rst_n,
  input logic enable,
  input logic [2:0] read_type,
  input logic [1:0] write_type,
  input logic [ramio_pkg::ADDR_W-1:0] address,
  input logic [ramio_pkg::DATA_W-1:0] data_in,
  output logic [ramio_pkg::DATA_W-1:0] data_out,
  output logic data_out_ready,
  output logic busy,
  output logic [3:0] led,
  output logic uart_tx,
  input logic uart_rx
);
  import ramio_pkg::*;

  io_sel_e sel;
  logic is_rd;
  logic is_wr;
  logic [DATA_W-1:0] io_rdata;
  logic [DATA_W-1:0] lane_data;
  logic lane_ready;
  logic lane_busy;
  // transmit staging, IDLE_WORD when nothing is being sent
  logic [DATA_W-1:0] tx_word;
  logic tx_go;
  // bsy from the transmitter lags go by a cycle
  logic tx_go_prev;
  logic tx_bsy;
  // last received byte, IDLE_WORD when empty
  logic [DATA_W-1:0] rx_word;
  logic rx_go;
  logic [7:0] rx_data;
  logic rx_ready;

  ram_port_if ram_bus ();

  // ------------------------------------------------------------
  // decode and response mux
  // ------------------------------------------------------------
  always_comb begin
    case (address)
      ADDR_LED: sel = SEL_LED;
      ADDR_UART_OUT: sel = SEL_UART_OUT;
      ADDR_UART_IN: sel = SEL_UART_IN;
      default: sel = SEL_RAM;
    endcase
    case (sel)
      SEL_LED: io_rdata = {{(DATA_W - 4){1'b0}}, led};
      SEL_UART_OUT: io_rdata = tx_word;
      SEL_UART_IN: io_rdata = rx_word;
      default: io_rdata = '0;
    endcase
  end

  assign is_rd = read_type != 3'b000;
  assign is_wr = write_type != 2'b00;

  // I/O answers in the same cycle and is never busy
  assign data_out = (sel == SEL_RAM) ? lane_data : io_rdata;
  assign data_out_ready = (sel == SEL_RAM) ? lane_ready : enable;
  assign busy = (sel == SEL_RAM) ? lane_busy : 1'b0;

  // ------------------------------------------------------------
  // I/O registers
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led <= 4'b1111;
      tx_word <= IDLE_WORD;
      tx_go <= 1'b0;
      tx_go_prev <= 1'b0;
      rx_word <= IDLE_WORD;
      rx_go <= 1'b1;
    end else begin
      tx_go_prev <= 1'b0;
      // a read empties the receive register, ahead of a new byte
      if (enable && is_rd && sel == SEL_UART_IN) begin
        rx_word <= IDLE_WORD;
      end else if (rx_go && rx_ready) begin
        rx_word <= {{(DATA_W - 8){1'b0}}, rx_data};
        rx_go <= 1'b0;
      end
      // one cycle low acknowledges the receiver
      if (!rx_go) begin
        rx_go <= 1'b1;
      end
      // frame finished, release the transmitter
      if (tx_go && !tx_bsy && !tx_go_prev) begin
        tx_go <= 1'b0;
        tx_word <= IDLE_WORD;
      end
      if (enable && is_wr && sel == SEL_UART_OUT) begin
        tx_word <= {{(DATA_W - 8){1'b0}}, data_in[7:0]};
        tx_go <= 1'b1;
        tx_go_prev <= 1'b1;
      end
      if (enable && is_wr && sel == SEL_LED) begin
        led <= data_in[3:0];
      end
    end
  end

  lane_align u_lane_align (
    .clk(clk),
    .rst_n(rst_n),
    .req(enable && sel == SEL_RAM),
    .read_type(read_type),
    .write_type(access_size_e'(write_type)),
    .address(address),
    .data_in(data_in),
    .data_out(lane_data),
    .data_ready(lane_ready),
    .busy(lane_busy),
    .ram(ram_bus)
  );

  word_ram u_word_ram (
    .clk(clk),
    .ram(ram_bus)
  );

  uart_tx u_uart_tx (
    .clk(clk),
    .rst_n(rst_n),
    .go(tx_go),
    .data(tx_word[7:0]),
    .bsy(tx_bsy),
    .tx(uart_tx)
  );

  uart_rx u_uart_rx (
    .clk(clk),
    .rst_n(rst_n),
    .go(rx_go),
    .rx(uart_rx),
    .data(rx_data),
    .data_ready(rx_ready)
  );

  // client issues a read or a write, never both
  a_one_op: assert property (@(posedge clk) disable iff (!rst_n)
    enable |-> !(is_rd && is_wr));

endmodule

// File: rtl/uart_rx.sv
/*
  UART receiver
  8N1 frames, start bit rechecked at mid bit, data sampled at mid bit,
  byte held with data_ready until go drops
*/
`timescale 1ns/1ps

module uart_rx (
  input logic clk,
  input logic rst_n,
  input logic go,
  input logic rx,
  output logic [7:0] data,
  output logic data_ready
);
  import ramio_pkg::*;

  uart_state_e state;
  logic [CLK_CNT_W-1:0] clk_cnt;
  logic [2:0] bit_idx;
  logic rx_meta;
  logic rx_sync;
  logic half_end;
  logic bit_end;

  assign half_end = clk_cnt == CLK_CNT_W'(CLKS_PER_BIT / 2 - 1);
  assign bit_end = clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1);

  // ------------------------------------------------------------
  // two flop synchronizer, idles high
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  // ------------------------------------------------------------
  // frame FSM
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= UART_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      data_ready <= 1'b0;
    end else begin
      // go low is the acknowledgment
      if (!go) begin
        data_ready <= 1'b0;
      end
      clk_cnt <= clk_cnt + 1'b1;
      case (state)
        UART_IDLE: begin
          clk_cnt <= '0;
          if (go && !rx_sync) begin
            state <= UART_START;
          end
        end
        UART_START: begin
          // half a bit in, a glitch has gone high again
          if (half_end) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state <= rx_sync ? UART_IDLE : UART_DATA;
          end
        end
        UART_DATA: begin
          if (bit_end) begin
            clk_cnt <= '0;
            data[bit_idx] <= rx_sync;
            if (bit_idx == 3'd7) begin
              state <= UART_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        UART_STOP: begin
          if (bit_end) begin
            // framing error drops the byte
            data_ready <= rx_sync ? 1'b1 : data_ready;
            state <= UART_IDLE;
          end
        end
        default: state <= UART_IDLE;
      endcase
    end
  end

endmodule

// File: rtl/uart_tx.sv
/*
  UART transmitter
  sends one 8N1 frame per rising go, LSB first, CLKS_PER_BIT clocks per bit
*/
`timescale 1ns/1ps

module uart_tx (
  input logic clk,
  input logic rst_n,
  input logic go,
  input logic [7:0] data,
  output logic bsy,
  output logic tx
);
  import ramio_pkg::*;

  uart_state_e state;
  logic [CLK_CNT_W-1:0] clk_cnt;
  logic [2:0] bit_idx;
  logic [7:0] tx_byte;
  // frame done, wait for go to drop before the next one
  logic sent;

  logic bit_end;
  assign bit_end = clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1);
  assign bsy = state != UART_IDLE;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= UART_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      sent <= 1'b0;
      tx <= 1'b1;
    end else begin
      clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
      case (state)
        UART_IDLE: begin
          clk_cnt <= '0;
          tx <= 1'b1;
          if (!go) begin
            sent <= 1'b0;
          end else if (!sent) begin
            // latch the byte, start bit goes out now
            tx_byte <= data;
            tx <= 1'b0;
            state <= UART_START;
          end
        end
        UART_START: begin
          if (bit_end) begin
            bit_idx <= '0;
            tx <= tx_byte[0];
            state <= UART_DATA;
          end
        end
        UART_DATA: begin
          if (bit_end) begin
            if (bit_idx == 3'd7) begin
              tx <= 1'b1;
              state <= UART_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              tx <= tx_byte[bit_idx + 3'd1];
            end
          end
        end
        UART_STOP: begin
          if (bit_end) begin
            sent <= 1'b1;
            state <= UART_IDLE;
          end
        end
        default: state <= UART_IDLE;
      endcase
    end
  end

  // line rests high between frames
  a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    state == UART_IDLE |-> tx);

endmodule

// File: rtl/word_ram.sv
/*
  local word RAM
  2^RAM_WORDS_W words, per byte write enables, one cycle read latency
*/
`timescale 1ns/1ps

module word_ram (
  input logic clk,
  ram_port_if.responder ram
);
  import ramio_pkg::*;

  logic [DATA_W-1:0] mem [2**RAM_WORDS_W];
  logic rd_en;

  // a request with no byte enables is a read
  assign rd_en = ram.req && (ram.byte_en == '0);

  // ------------------------------------------------------------
  // byte lane writes
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    for (int i = 0; i < BYTE_LANES; i++) begin
      if (ram.req && ram.byte_en[i]) begin
        mem[ram.word_addr][8*i +: 8] <= ram.wr_data[8*i +: 8];
      end
    end
  end

  // ------------------------------------------------------------
  // registered read
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    // a held read keeps refreshing the same word
    if (rd_en) begin
      ram.rd_data <= mem[ram.word_addr];
    end
    // valid follows the request by one cycle, writes give no response
    ram.rd_valid <= rd_en;
  end

  // a held read keeps its word address or the valid data would be stale
  a_read_addr_held: assert property (@(posedge clk)
    rd_en && $past(rd_en) |-> $stable(ram.word_addr));

endmodule

// File: rtl/lane_align.sv
/*
  lane aligner
  turns byte / half / word accesses into byte enabled word writes,
  picks read lanes out of the RAM word and sign or zero extends them
*/
`timescale 1ns/1ps

module lane_align (
  input logic clk,
  input logic rst_n,
  input logic req,
  input logic [2:0] read_type,
  input ramio_pkg::access_size_e write_type,
  input logic [ramio_pkg::ADDR_W-1:0] address,
  input logic [ramio_pkg::DATA_W-1:0] data_in,
  output logic [ramio_pkg::DATA_W-1:0] data_out,
  output logic data_ready,
  output logic busy,
  ram_port_if.requester ram
);
  import ramio_pkg::*;

  access_size_e rd_size;
  logic rd_sign;
  logic is_read;
  logic is_write;
  logic [1:0] offset;
  logic [7:0] rd_byte;
  logic [15:0] rd_half;

  // bit 2 of read_type asks for sign extension
  assign rd_size = access_size_e'(read_type[1:0]);
  assign rd_sign = read_type[2];
  assign is_read = rd_size != SIZE_NONE;
  assign is_write = write_type != SIZE_NONE;
  assign offset = address[1:0];

  // ------------------------------------------------------------
  // write lane steering
  // ------------------------------------------------------------
  always_comb begin
    ram.byte_en = '0;
    ram.wr_data = data_in;
    case (write_type)
      SIZE_BYTE: begin
        // byte copied to every lane, enable picks one
        ram.byte_en = 4'b0001 << offset;
        ram.wr_data = {4{data_in[7:0]}};
      end
      SIZE_HALF: begin
        ram.wr_data = {2{data_in[15:0]}};
        // odd offset is misaligned, nothing written
        if (!offset[0]) begin
          ram.byte_en = offset[1] ? 4'b1100 : 4'b0011;
        end
      end
      SIZE_WORD: ram.byte_en = '1;
      default: ;
    endcase
  end

  // a dropped write must not look like a read to the RAM
  assign ram.req = req && (is_read || (is_write && ram.byte_en != '0));
  assign ram.word_addr = address[RAM_WORDS_W+1:2];

  // ------------------------------------------------------------
  // read lane extraction
  // ------------------------------------------------------------
  always_comb begin
    rd_byte = ram.rd_data[8*offset +: 8];
    rd_half = offset[1] ? ram.rd_data[31:16] : ram.rd_data[15:0];
    case (rd_size)
      SIZE_BYTE: data_out = {{24{rd_sign & rd_byte[7]}}, rd_byte};
      SIZE_HALF: data_out = offset[0] ? '0 : {{16{rd_sign & rd_half[15]}}, rd_half};
      SIZE_WORD: data_out = ram.rd_data;
      default: data_out = '0;
    endcase
  end

  // busy only while a read waits for its word
  assign data_ready = req && is_read && ram.rd_valid;
  assign busy = req && is_read && !ram.rd_valid;

  // a RAM read spends one cycle busy before its word comes back
  a_busy_before_ready: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(data_ready) |-> $past(busy));

endmodule

// File: rtl/ram_port_if.sv
/*
  word RAM port
  word aligned requests with byte enables, registered read data back
*/
`timescale 1ns/1ps

interface ram_port_if;
  import ramio_pkg::*;

  // request side, a read is req with byte_en all zero
  logic req;
  logic [RAM_WORDS_W-1:0] word_addr;
  logic [DATA_W-1:0] wr_data;
  logic [BYTE_LANES-1:0] byte_en;

  // response side, valid the cycle after a read request
  logic [DATA_W-1:0] rd_data;
  logic rd_valid;

  modport requester(output req, word_addr, wr_data, byte_en, input rd_data, rd_valid);

  modport responder(input req, word_addr, wr_data, byte_en, output rd_data, rd_valid);

endinterface

// File: rtl/ramio_pkg.sv
/*
  ramio shared definitions
  client bus widths, the I/O address map, UART bit timing
  and the enums used by the decoder, lane aligner and UARTs
*/
package ramio_pkg;

  // ------------------------------------------------------------
  // client bus
  // ------------------------------------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BYTE_LANES = DATA_W / 8;

  // local RAM depth, as word address bits (256 words)
  localparam int RAM_WORDS_W = 8;

  // ------------------------------------------------------------
  // I/O map, top words of the address space
  // ------------------------------------------------------------
  localparam logic [ADDR_W-1:0] ADDR_TOP_WORD = 32'hffff_fffc;
  localparam logic [ADDR_W-1:0] ADDR_UART_OUT = ADDR_TOP_WORD - 32'd4;
  localparam logic [ADDR_W-1:0] ADDR_UART_IN = ADDR_TOP_WORD - 32'd8;
  // 4 leds in the low nibble, 0 lights a led
  localparam logic [ADDR_W-1:0] ADDR_LED = ADDR_TOP_WORD - 32'd12;

  // idle transmitter / empty receiver marker
  localparam logic [DATA_W-1:0] IDLE_WORD = '1;

  // UART bit time in clocks
  localparam int CLKS_PER_BIT = 8;
  localparam int CLK_CNT_W = $clog2(CLKS_PER_BIT);

  // ------------------------------------------------------------
  // enums
  // ------------------------------------------------------------
  // low two bits of read_type / write_type
  typedef enum logic [1:0] {
    SIZE_NONE = 2'b00,
    SIZE_BYTE = 2'b01,
    SIZE_HALF = 2'b10,
    SIZE_WORD = 2'b11
  } access_size_e;

  typedef enum logic [1:0] {SEL_RAM, SEL_LED, SEL_UART_OUT, SEL_UART_IN} io_sel_e;

  typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_e;

endpackage
